// ==== include/cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// address geometry
// ----------------------------------------------------------------------
`define BW_WORD_ADDR 16 // core issues word addresses
`define BW_BLOCK 2 // four words per block
`define BW_SET 4 // sixteen sets

// whatever is left above set and word is tag
`define BW_TAG (`BW_WORD_ADDR - `BW_SET - `BW_BLOCK)

// capacity
// ----------------------------------------------------------------------
`define CACHE_BLOCK_CAPACITY 32 // blocks over both ways

`endif

// ==== design/cache_types_pkg.sv ====
`include "cache_macros.svh"

package cache_types_pkg;

	// address fields
	// ------------------------------------------------------------------
	typedef logic [`BW_WORD_ADDR-1:0] word_addr_t; // full core word address
	typedef logic [`BW_TAG-1:0] tag_t; // upper address bits
	typedef logic [`BW_SET-1:0] set_idx_t; // set select
	typedef logic [`BW_BLOCK-1:0] word_idx_t; // word within block

	// payload and way
	typedef logic [31:0] data_t;
	typedef logic way_t; // two ways, so one bit

	// controller FSM
	// ------------------------------------------------------------------
	typedef enum logic [2:0] {
		IDLE, // waiting on a fresh request
		LOOKUP, // tag compare, data read issued
		RESPOND, // done pulse to core
		WRITEBACK, // dirty victim out to memory
		FILL, // block in from memory
		UPDATE // tag install and write merge
	} ctrl_state_t;

endpackage

// ==== design/perf_types_pkg.sv ====
package perf_types_pkg;

	// event counters
	typedef logic [31:0] perf_count_t; // saturates at all ones

	localparam int unsigned PERF_EVENTS = 3; // hit, miss, writeback

	// counter select, carried in comm_i[1:0]
	typedef enum logic [1:0] {
		SEL_HIT = 2'd0,
		SEL_MISS = 2'd1,
		SEL_WRITEBACK = 2'd2
	} perf_sel_t;

endpackage

// ==== design/tag_memory_2way.sv ====
`timescale 1ns/10ps
`include "cache_macros.svh"

module tag_memory_2way import cache_types_pkg::*; (
	input logic clock_i,
	input logic rst_n_i,

	// lookup address
	input set_idx_t set_i,
	input tag_t tag_i,

	// updates from controller
	input logic tag_we_i, // install tag_i into way_i
	input way_t way_i,
	input logic dirty_set_i, // mark way_i dirty
	input logic lru_touch_i, // way_i becomes most recent

	// compare results
	output logic hit_o,
	output way_t hit_way_o,
	output way_t victim_way_o, // LRU way of the set
	output tag_t victim_tag_o,
	output logic victim_dirty_o
);

localparam int unsigned SETS = `CACHE_BLOCK_CAPACITY / 2; // two blocks per set

// state arrays
// ----------------------------------------------------------------------
tag_t tag_q [2][SETS];
logic valid_q [2][SETS];
logic dirty_q [2][SETS];
way_t lru_q [SETS]; // holds the least recent way

logic hit_w0, hit_w1;

// both ways compared in parallel
assign hit_w0 = valid_q[0][set_i] && (tag_q[0][set_i] == tag_i);
assign hit_w1 = valid_q[1][set_i] && (tag_q[1][set_i] == tag_i);

assign hit_o = hit_w0 | hit_w1;
assign hit_way_o = hit_w1; // way 0 unless way 1 matched

// victim is strictly the LRU way
assign victim_way_o = lru_q[set_i];
assign victim_tag_o = tag_q[victim_way_o][set_i];
assign victim_dirty_o = valid_q[victim_way_o][set_i] & dirty_q[victim_way_o][set_i];

// updates
// ----------------------------------------------------------------------
always_ff @(posedge clock_i) begin
	if (!rst_n_i) begin
		tag_q <= '{default: '0};
		valid_q <= '{default: 1'b0}; // whole cache invalid
		dirty_q <= '{default: 1'b0};
		lru_q <= '{default: 1'b0}; // way 0 goes first
	end else begin
		if (tag_we_i) begin
			tag_q[way_i][set_i] <= tag_i;
			valid_q[way_i][set_i] <= 1'b1;
			dirty_q[way_i][set_i] <= 1'b0; // fresh block matches memory
		end
		if (dirty_set_i) dirty_q[way_i][set_i] <= 1'b1; // wins over the clear
		if (lru_touch_i) lru_q[set_i] <= ~way_i; // other way now LRU
	end
end

endmodule

// ==== design/cache_data_memory.sv ====
`timescale 1ns/10ps
`include "cache_macros.svh"

module cache_data_memory import cache_types_pkg::*; (
	input logic clock_i,
	input way_t way_i,
	input set_idx_t set_i,
	input word_idx_t word_i,
	input logic we_i,
	input data_t data_i,
	output data_t data_o // one cycle after address
);

localparam int unsigned DEPTH = `CACHE_BLOCK_CAPACITY * (1 << `BW_BLOCK);
localparam int unsigned BW_ADDR = $clog2(DEPTH);

data_t mem_q [DEPTH];
logic [BW_ADDR-1:0] addr_w;

assign addr_w = {way_i, set_i, word_i}; // [way|set|word]

// read first, a write in the same cycle shows up on the next read
always_ff @(posedge clock_i) begin
	if (we_i) mem_q[addr_w] <= data_i;
	data_o <= mem_q[addr_w];
end

endmodule

// ==== design/cache_performance_controller.sv ====
`timescale 1ns/10ps

module cache_performance_controller import perf_types_pkg::*; (
	input logic clock_i,
	input logic rst_n_i,

	// event strobes from controller
	input logic hit_i,
	input logic miss_i,
	input logic writeback_i,

	// comm port
	input logic [31:0] comm_i, // [31] clear, [1:0] select
	output logic [31:0] comm_o
);

perf_count_t count_q [PERF_EVENTS];
logic [PERF_EVENTS-1:0] event_w;
perf_sel_t sel_w;
perf_count_t sel_count;

assign event_w = {writeback_i, miss_i, hit_i}; // same order as perf_sel_t
assign sel_w = perf_sel_t'(comm_i[1:0]);

// counters
// ----------------------------------------------------------------------
always_ff @(posedge clock_i) begin
	if (!rst_n_i || comm_i[31]) begin
		for (int i = 0; i < PERF_EVENTS; i++) count_q[i] <= '0;
	end else begin
		for (int i = 0; i < PERF_EVENTS; i++) begin
			// hold at max rather than wrap
			if (event_w[i] && (count_q[i] != '1)) count_q[i] <= count_q[i] + 1'b1;
		end
	end
end

// readback
// ----------------------------------------------------------------------
always_comb begin
	case (sel_w)
		SEL_HIT: sel_count = count_q[SEL_HIT];
		SEL_MISS: sel_count = count_q[SEL_MISS];
		SEL_WRITEBACK: sel_count = count_q[SEL_WRITEBACK];
		default: sel_count = '0; // code 3 unused
	endcase
end

always_ff @(posedge clock_i) begin
	if (!rst_n_i) comm_o <= '0;
	else comm_o <= sel_count; // one cycle behind comm_i
end

endmodule

// ==== design/cache_2way_controller.sv ====
`timescale 1ns/10ps

module cache_2way_controller import cache_types_pkg::*; (
	input logic clock_i,
	input logic rst_n_i,

	// core side
	input logic core_req_i,
	input logic core_rw_i, // 1 write, 0 read
	input tag_t core_tag_i,
	input set_idx_t core_set_i,
	input word_idx_t core_word_i,
	input data_t core_data_i,
	output logic core_done_o,
	output logic core_hit_o,
	output data_t core_data_o,

	// tag memory
	input logic tag_hit_i,
	input way_t tag_hit_way_i,
	input way_t tag_victim_way_i,
	input tag_t tag_victim_tag_i,
	input logic tag_victim_dirty_i,
	output logic tag_we_o,
	output way_t tag_way_o,
	output logic tag_dirty_set_o,
	output logic tag_lru_touch_o,

	// data memory
	output way_t cache_mem_way_o,
	output word_idx_t cache_mem_word_o,
	output logic cache_mem_we_o,
	output data_t cache_mem_data_o,
	input data_t cache_mem_data_i,

	// wishbone master
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic wb_we_o,
	output word_addr_t wb_adr_o,
	output data_t wb_dat_o,
	input data_t wb_dat_i,
	input logic wb_ack_i,

	// perf events
	output logic flag_hit_o,
	output logic flag_miss_o,
	output logic flag_writeback_o
);

ctrl_state_t state_q, state_d;
word_idx_t word_cnt_q; // block word on the bus
logic hit_q; // lookup result, shown at done
logic drop_wait_q; // core still holds the old request
way_t victim_way_q;
tag_t victim_tag_q;

logic lookup_w, hit_w, bus_active, last_word;

assign lookup_w = (state_q == LOOKUP);
assign hit_w = lookup_w & tag_hit_i;
assign bus_active = (state_q == WRITEBACK) || (state_q == FILL);
assign last_word = (word_cnt_q == '1);

// next state
// ----------------------------------------------------------------------
always_comb begin
	state_d = state_q;
	case (state_q)
		IDLE: if (core_req_i && !drop_wait_q) state_d = LOOKUP;
		LOOKUP: begin
			if (tag_hit_i) state_d = RESPOND;
			else if (tag_victim_dirty_i) state_d = WRITEBACK; // evict first
			else state_d = FILL;
		end
		WRITEBACK: if (wb_ack_i && last_word) state_d = FILL;
		FILL: if (wb_ack_i && last_word) state_d = UPDATE;
		UPDATE: state_d = RESPOND;
		RESPOND: state_d = IDLE;
		default: state_d = IDLE;
	endcase
end

always_ff @(posedge clock_i) begin
	if (!rst_n_i) begin
		state_q <= IDLE;
		word_cnt_q <= '0;
		hit_q <= 1'b0;
		drop_wait_q <= 1'b0;
	end else begin
		state_q <= state_d;
		if (lookup_w) begin
			hit_q <= tag_hit_i;
			word_cnt_q <= '0; // every burst starts at word 0
		end else if (bus_active && wb_ack_i) begin
			word_cnt_q <= word_cnt_q + 1'b1; // wraps between writeback and fill
		end
		if (state_q == RESPOND) drop_wait_q <= 1'b1;
		else if (!core_req_i) drop_wait_q <= 1'b0;
	end
end

// victim held for the whole miss
always_ff @(posedge clock_i) begin
	if (lookup_w) begin
		victim_way_q <= tag_victim_way_i;
		victim_tag_q <= tag_victim_tag_i;
	end
end

// data memory steering
// ----------------------------------------------------------------------
always_comb begin
	cache_mem_way_o = victim_way_q;
	cache_mem_word_o = core_word_i;
	cache_mem_we_o = 1'b0;
	cache_mem_data_o = core_data_i;
	case (state_q)
		LOOKUP: begin
			// hit accesses the word, miss preloads victim word 0
			cache_mem_way_o = tag_hit_i ? tag_hit_way_i : tag_victim_way_i;
			cache_mem_word_o = tag_hit_i ? core_word_i : '0;
			cache_mem_we_o = tag_hit_i & core_rw_i;
		end
		WRITEBACK: begin
			// read one word ahead so wb_dat_o is ready after ack
			cache_mem_word_o = wb_ack_i ? word_cnt_q + 1'b1 : word_cnt_q;
		end
		FILL: begin
			cache_mem_word_o = word_cnt_q;
			cache_mem_we_o = wb_ack_i;
			cache_mem_data_o = wb_dat_i;
		end
		UPDATE: cache_mem_we_o = core_rw_i; // merge store, or read for respond
		default: ;
	endcase
end

// tag memory strobes
assign tag_way_o = lookup_w ? tag_hit_way_i : victim_way_q;
assign tag_we_o = (state_q == UPDATE);
assign tag_lru_touch_o = hit_w || (state_q == UPDATE);
assign tag_dirty_set_o = core_rw_i & (hit_w || (state_q == UPDATE));

// wishbone
// ----------------------------------------------------------------------
assign wb_cyc_o = bus_active;
assign wb_stb_o = bus_active;
assign wb_we_o = (state_q == WRITEBACK);
assign wb_adr_o = {(state_q == WRITEBACK) ? victim_tag_q : core_tag_i, core_set_i, word_cnt_q};
assign wb_dat_o = cache_mem_data_i;

// core response
assign core_done_o = (state_q == RESPOND);
assign core_hit_o = core_done_o & hit_q;
assign core_data_o = cache_mem_data_i;

// perf events, one per access in lookup
assign flag_hit_o = hit_w;
assign flag_miss_o = lookup_w & ~tag_hit_i;
assign flag_writeback_o = lookup_w & ~tag_hit_i & tag_victim_dirty_i;

endmodule

// ==== design/cache_2way.sv ====
`timescale 1ns/10ps
`include "cache_macros.svh"

module cache_2way import cache_types_pkg::*; (
	input logic clock_i,
	input logic rst_n_i,
	input logic [31:0] comm_i, // counter select and clear
	output logic [31:0] comm_o,

	// core
	input logic core_req_i,
	input logic core_rw_i,
	input word_addr_t core_add_i,
	input data_t core_data_i,
	output logic core_done_o,
	output data_t core_data_o,
	output logic hit_o,

	// wishbone master
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic wb_we_o,
	output word_addr_t wb_adr_o,
	output data_t wb_dat_o,
	input data_t wb_dat_i,
	input logic wb_ack_i
);

// address split [tag|set|word]
// ----------------------------------------------------------------------
tag_t req_tag;
set_idx_t req_set;
word_idx_t req_word;

assign req_tag = core_add_i[`BW_WORD_ADDR-1:`BW_SET+`BW_BLOCK];
assign req_set = core_add_i[`BW_SET+`BW_BLOCK-1:`BW_BLOCK];
assign req_word = core_add_i[`BW_BLOCK-1:0];

// block interconnect
logic tag_hit, tag_victim_dirty, tag_we, tag_dirty_set, tag_lru_touch;
way_t tag_hit_way, tag_victim_way, tag_way;
tag_t tag_victim_tag;
way_t mem_way;
word_idx_t mem_word;
logic mem_we;
data_t mem_wdata, mem_rdata;
logic hit_flag, miss_flag, wb_flag;

// tag memory
// ----------------------------------------------------------------------
tag_memory_2way tag_mem_inst (
	.clock_i (clock_i),
	.rst_n_i (rst_n_i),
	.set_i (req_set),
	.tag_i (req_tag),
	.tag_we_i (tag_we),
	.way_i (tag_way),
	.dirty_set_i (tag_dirty_set),
	.lru_touch_i (tag_lru_touch),
	.hit_o (tag_hit),
	.hit_way_o (tag_hit_way),
	.victim_way_o (tag_victim_way),
	.victim_tag_o (tag_victim_tag),
	.victim_dirty_o (tag_victim_dirty)
);

// data memory
// ----------------------------------------------------------------------
cache_data_memory data_mem_inst (
	.clock_i (clock_i),
	.way_i (mem_way),
	.set_i (req_set), // set always from the live request
	.word_i (mem_word),
	.we_i (mem_we),
	.data_i (mem_wdata),
	.data_o (mem_rdata)
);

// controller
// ----------------------------------------------------------------------
cache_2way_controller ctrl_inst (
	.clock_i (clock_i),
	.rst_n_i (rst_n_i),
	.core_req_i (core_req_i),
	.core_rw_i (core_rw_i),
	.core_tag_i (req_tag),
	.core_set_i (req_set),
	.core_word_i (req_word),
	.core_data_i (core_data_i),
	.core_done_o (core_done_o),
	.core_hit_o (hit_o),
	.core_data_o (core_data_o),
	.tag_hit_i (tag_hit),
	.tag_hit_way_i (tag_hit_way),
	.tag_victim_way_i (tag_victim_way),
	.tag_victim_tag_i (tag_victim_tag),
	.tag_victim_dirty_i (tag_victim_dirty),
	.tag_we_o (tag_we),
	.tag_way_o (tag_way),
	.tag_dirty_set_o (tag_dirty_set),
	.tag_lru_touch_o (tag_lru_touch),
	.cache_mem_way_o (mem_way),
	.cache_mem_word_o (mem_word),
	.cache_mem_we_o (mem_we),
	.cache_mem_data_o (mem_wdata),
	.cache_mem_data_i (mem_rdata),
	.wb_cyc_o (wb_cyc_o),
	.wb_stb_o (wb_stb_o),
	.wb_we_o (wb_we_o),
	.wb_adr_o (wb_adr_o),
	.wb_dat_o (wb_dat_o),
	.wb_dat_i (wb_dat_i),
	.wb_ack_i (wb_ack_i),
	.flag_hit_o (hit_flag),
	.flag_miss_o (miss_flag),
	.flag_writeback_o (wb_flag)
);

// performance counters
// ----------------------------------------------------------------------
cache_performance_controller perf_inst (
	.clock_i (clock_i),
	.rst_n_i (rst_n_i),
	.hit_i (hit_flag),
	.miss_i (miss_flag),
	.writeback_i (wb_flag),
	.comm_i (comm_i),
	.comm_o (comm_o)
);

endmodule

// ==== dv/wb_mem_model.sv ====
`timescale 1ns/10ps
`include "cache_macros.svh"

module wb_mem_model import cache_types_pkg::*; (
	input logic clock_i,
	input logic rst_n_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input word_addr_t wb_adr_i,
	input data_t wb_dat_i,
	output data_t wb_dat_o, // valid with ack
	output logic wb_ack_o
);

localparam int unsigned WORDS = 1 << `BW_WORD_ADDR;

data_t mem [WORDS];
logic busy_q; // word accepted, ack still pending
logic [1:0] delay_q;

// each word starts as a function of its own address
initial begin
	for (int a = 0; a < WORDS; a++) begin
		mem[a] = {word_addr_t'(~a), word_addr_t'(a)} ^ 32'h3c5a_96e1;
	end
end

always @(posedge clock_i) begin
	logic go;
	int unsigned pick;
	go = 1'b0;
	if (!rst_n_i) begin
		wb_ack_o <= 1'b0;
		wb_dat_o <= '0;
		busy_q <= 1'b0;
		delay_q <= '0;
	end else begin
		wb_ack_o <= 1'b0; // single cycle ack
		if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
			if (!busy_q) begin
				pick = $urandom_range(0, 3); // extra wait cycles
				if (pick == 0) go = 1'b1;
				else begin
					busy_q <= 1'b1;
					delay_q <= 2'(pick - 1);
				end
			end else if (delay_q == 0) begin
				go = 1'b1;
				busy_q <= 1'b0;
			end else delay_q <= delay_q - 1'b1;
		end
		if (go) begin
			wb_ack_o <= 1'b1;
			if (wb_we_i) mem[wb_adr_i] <= wb_dat_i;
			else wb_dat_o <= mem[wb_adr_i];
		end
	end
end

endmodule

// ==== dv/cache_2way_properties.sv ====
`timescale 1ns/10ps

module cache_2way_properties import cache_types_pkg::*; (
	input logic clock_i,
	input logic rst_n_i,
	input logic done_i,
	input logic hit_i,
	input logic cyc_i,
	input logic stb_i,
	input logic we_i,
	input word_addr_t adr_i,
	input data_t dat_i,
	input logic ack_i
);

int unsigned fail_count = 0; // read back by the testbench

// wishbone classic rules
// ----------------------------------------------------------------------
// slave acks only inside a strobed cycle
ack_in_cycle: assert property (@(posedge clock_i) disable iff (!rst_n_i) ack_i |-> cyc_i && stb_i)
	else begin
		fail_count++;
		$error("wishbone ack outside an active cyc and stb");
	end

// address and strobe hold until the slave acks
adr_hold: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		stb_i && !ack_i |=> stb_i && $stable(adr_i))
	else begin
		fail_count++;
		$error("wishbone address or stb changed before ack");
	end

wdata_hold: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		stb_i && we_i && !ack_i |=> $stable(dat_i))
	else begin
		fail_count++;
		$error("wishbone write data changed before ack");
	end

// core side
// ----------------------------------------------------------------------
done_pulse: assert property (@(posedge clock_i) disable iff (!rst_n_i) done_i |=> !done_i)
	else begin
		fail_count++;
		$error("core done held longer than one cycle");
	end

// a hit goes idle, lookup, respond with no bus cycle in between
hit_quiet_bus: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		done_i && hit_i |-> !$past(cyc_i) && !$past(cyc_i, 2))
	else begin
		fail_count++;
		$error("wishbone cycle seen during a cache hit");
	end

endmodule

bind cache_2way cache_2way_properties props_inst (
	.clock_i (clock_i),
	.rst_n_i (rst_n_i),
	.done_i (core_done_o),
	.hit_i (hit_o),
	.cyc_i (wb_cyc_o),
	.stb_i (wb_stb_o),
	.we_i (wb_we_o),
	.adr_i (wb_adr_o),
	.dat_i (wb_dat_o),
	.ack_i (wb_ack_i)
);

// ==== dv/cache_2way_tb.sv ====
`timescale 1ns/10ps
`include "cache_macros.svh"

module cache_2way_tb import cache_types_pkg::*, perf_types_pkg::*; ();

localparam int unsigned SETS = `CACHE_BLOCK_CAPACITY / 2;
localparam int unsigned TIMEOUT = 200; // cycles allowed per wait
localparam int unsigned N_RANDOM = 400;
localparam int DRIVE = 1; // ns after the rising edge

logic clk, rst_n;
logic [31:0] comm_sel, comm_rd;
logic req, rw, done, hit;
word_addr_t addr, wb_adr;
data_t wdata, rdata, wb_dat_w, wb_dat_r;
logic wb_cyc, wb_stb, wb_we, wb_ack;

// reference model state
tag_t m_tag [2][SETS];
logic m_valid [2][SETS];
logic m_dirty [2][SETS];
logic m_lru [SETS]; // least recent way
data_t shadow [int unsigned]; // words the core has written
int unsigned n_hit, n_miss, n_wb;
int unsigned errors, checks;
logic timed_out;

cache_2way dut (
	.clock_i (clk), .rst_n_i (rst_n), .comm_i (comm_sel), .comm_o (comm_rd),
	.core_req_i (req), .core_rw_i (rw), .core_add_i (addr), .core_data_i (wdata),
	.core_done_o (done), .core_data_o (rdata), .hit_o (hit),
	.wb_cyc_o (wb_cyc), .wb_stb_o (wb_stb), .wb_we_o (wb_we), .wb_adr_o (wb_adr),
	.wb_dat_o (wb_dat_w), .wb_dat_i (wb_dat_r), .wb_ack_i (wb_ack)
);

wb_mem_model mem_inst (
	.clock_i (clk), .rst_n_i (rst_n), .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb),
	.wb_we_i (wb_we), .wb_adr_i (wb_adr), .wb_dat_i (wb_dat_w),
	.wb_dat_o (wb_dat_r), .wb_ack_o (wb_ack)
);

initial begin
	clk = 1'b0;
	forever #20 clk = ~clk; // 40 ns period
end

// reference model
// ----------------------------------------------------------------------
function automatic data_t expected_word(input word_addr_t a);
	if (shadow.exists(a)) return shadow[a];
	return {~a, a} ^ 32'h3c5a_96e1; // untouched memory content
endfunction

function automatic logic model_access(input word_addr_t a, input logic wr);
	tag_t t;
	set_idx_t s;
	logic h;
	way_t w;
	t = a[`BW_WORD_ADDR-1:`BW_SET+`BW_BLOCK];
	s = a[`BW_SET+`BW_BLOCK-1:`BW_BLOCK];
	h = 1'b0;
	w = 1'b0;
	for (int i = 0; i < 2; i++) begin
		if (m_valid[i][s] && m_tag[i][s] == t) begin
			h = 1'b1;
			w = way_t'(i);
		end
	end
	if (h) n_hit++;
	else begin
		n_miss++;
		w = m_lru[s]; // evict LRU way
		if (m_valid[w][s] && m_dirty[w][s]) n_wb++;
		m_tag[w][s] = t;
		m_valid[w][s] = 1'b1;
		m_dirty[w][s] = 1'b0;
	end
	if (wr) m_dirty[w][s] = 1'b1;
	m_lru[s] = ~w;
	return h;
endfunction

// helpers
// ----------------------------------------------------------------------
task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
	checks++;
	assert (act === exp) else begin
		$display("[FAIL] %s expected %h actual %h", name, exp, act);
		errors++;
	end
endtask

task automatic core_access(input word_addr_t a, input logic wr, input data_t d,
		output data_t rd, output logic rh, output int unsigned lat);
	logic seen;
	seen = 1'b0;
	lat = 0;
	rd = '0;
	rh = 1'b0;
	if (timed_out) return;
	@(posedge clk);
	#DRIVE;
	req = 1'b1;
	rw = wr;
	addr = a;
	wdata = d;
	while (!seen && lat < TIMEOUT) begin
		@(posedge clk);
		lat++; // edges since the request went up
		@(negedge clk);
		seen = done;
	end
	if (!seen) begin
		$display("access to %h never finished, no done within %0d cycles", a, TIMEOUT);
		errors++;
		timed_out = 1'b1;
	end
	rd = rdata;
	rh = hit;
	@(posedge clk);
	#DRIVE;
	req = 1'b0; // one idle cycle before the next request
	rw = 1'b0;
endtask

task automatic checked_access(input string test, input word_addr_t a, input logic wr,
		input data_t d, output logic exp_hit, output int unsigned lat);
	data_t exp_data;
	data_t rd;
	logic rh;
	exp_data = expected_word(a);
	exp_hit = model_access(a, wr);
	core_access(a, wr, d, rd, rh, lat);
	check_value($sformatf("%s hit @%h", test, a), exp_hit, rh);
	if (!wr) check_value($sformatf("%s data @%h", test, a), exp_data, rd);
	else shadow[a] = d;
	if (exp_hit) check_value($sformatf("%s latency @%h", test, a), 2, lat);
endtask

task automatic read_counter(input perf_sel_t sel, output perf_count_t value);
	@(posedge clk);
	#DRIVE;
	comm_sel = {30'b0, sel};
	@(posedge clk); // comm_o registers the selection
	@(negedge clk);
	value = comm_rd;
endtask

task automatic report_test(input string name, input int unsigned err_before);
	if (errors == err_before) $display("test %s: ok", name);
	else $display("test %s: %0d errors", name, errors - err_before);
endtask

// tests
// ----------------------------------------------------------------------
task automatic verify_reset_state();
	int unsigned e0;
	perf_count_t v;
	e0 = errors;
	@(negedge clk);
	check_value("reset_state done", 0, done);
	check_value("reset_state hit", 0, hit);
	check_value("reset_state wb_cyc", 0, wb_cyc);
	for (int i = 0; i < PERF_EVENTS; i++) begin
		read_counter(perf_sel_t'(i), v);
		check_value($sformatf("reset_state counter %0d", i), 0, v);
	end
	report_test("reset_state", e0);
endtask

task automatic read_untouched_addresses();
	int unsigned e0, lat;
	logic ph;
	e0 = errors;
	checked_access("untouched_reads", 16'h1230, 1'b0, '0, ph, lat); // cold miss
	checked_access("untouched_reads", 16'h1230, 1'b0, '0, ph, lat); // repeat hits
	checked_access("untouched_reads", 16'h1233, 1'b0, '0, ph, lat); // same block
	checked_access("untouched_reads", 16'h7f04, 1'b0, '0, ph, lat);
	checked_access("untouched_reads", 16'h7f04, 1'b0, '0, ph, lat);
	report_test("untouched_reads", e0);
endtask

task automatic measure_hit_latency();
	int unsigned e0, lat;
	logic ph;
	e0 = errors;
	checked_access("hit_latency", 16'h2a18, 1'b0, '0, ph, lat);
	checked_access("hit_latency", 16'h2a19, 1'b0, '0, ph, lat);
	checked_access("hit_latency", 16'h2a1a, 1'b1, 32'hc0de_0001, ph, lat); // write hit
	checked_access("hit_latency", 16'h2a1a, 1'b0, '0, ph, lat);
	report_test("hit_latency", e0);
endtask

task automatic run_random_mix();
	int unsigned e0, lat, t, s, w;
	logic wr, ph;
	word_addr_t a;
	data_t d;
	e0 = errors;
	for (int i = 0; i < N_RANDOM; i++) begin
		if (timed_out) break;
		t = $urandom_range(0, 5); // six tags fight over two ways
		s = $urandom_range(0, 3);
		w = $urandom_range(0, 3);
		a = {tag_t'(t), set_idx_t'(s), word_idx_t'(w)};
		wr = 1'($urandom_range(0, 1));
		d = $urandom;
		checked_access("random_mix", a, wr, d, ph, lat);
	end
	report_test("random_mix", e0);
endtask

task automatic verify_counters();
	int unsigned e0;
	perf_count_t v;
	e0 = errors;
	read_counter(SEL_HIT, v);
	check_value("counters hit", n_hit, v);
	read_counter(SEL_MISS, v);
	check_value("counters miss", n_miss, v);
	read_counter(SEL_WRITEBACK, v);
	check_value("counters writeback", n_wb, v);
	// clear strobe on bit 31
	@(posedge clk);
	#DRIVE;
	comm_sel = 32'h8000_0000;
	@(posedge clk);
	#DRIVE;
	comm_sel = '0;
	for (int i = 0; i < PERF_EVENTS; i++) begin
		read_counter(perf_sel_t'(i), v);
		check_value($sformatf("counters cleared %0d", i), 0, v);
	end
	report_test("counters", e0);
endtask

// main sequence
// ----------------------------------------------------------------------
initial begin
	void'($urandom(32'h20b4_5d2e));
	rst_n = 1'b0;
	comm_sel = '0;
	req = 1'b0;
	rw = 1'b0;
	addr = '0;
	wdata = '0;
	errors = 0;
	checks = 0;
	timed_out = 1'b0;
	n_hit = 0;
	n_miss = 0;
	n_wb = 0;
	for (int s = 0; s < SETS; s++) begin
		m_lru[s] = 1'b0;
		for (int w = 0; w < 2; w++) begin
			m_tag[w][s] = '0;
			m_valid[w][s] = 1'b0;
			m_dirty[w][s] = 1'b0;
		end
	end
	repeat (5) @(posedge clk);
	#DRIVE;
	rst_n = 1'b1;
	verify_reset_state();
	read_untouched_addresses();
	measure_hit_latency();
	run_random_mix();
	verify_counters();
	$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
		dut.props_inst.fail_count);
	if (errors == 0 && !timed_out && dut.props_inst.fail_count == 0) begin
		$display("ALL TESTS PASSED");
	end else begin
		$display("SOME TESTS FAILED");
	end
	$finish;
end

endmodule

// ==== build.f ====
+incdir+include
design/cache_types_pkg.sv
design/perf_types_pkg.sv
design/tag_memory_2way.sv
design/cache_data_memory.sv
design/cache_performance_controller.sv
design/cache_2way_controller.sv
design/cache_2way.sv
dv/wb_mem_model.sv
dv/cache_2way_properties.sv
dv/cache_2way_tb.sv

// ==== Makefile ====
# Verilator build and run of the cache testbench

VERILATOR ?= verilator
TOP ?= cache_2way_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS ?= +verilator+error+limit+1000
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
